/* verilog/scaler_pkg.sv */
// shared widths, fixed-point constants and bus structs of the image scaler
// every RTL block pulls these in with a wildcard import
`default_nettype none

package scaler_pkg;

    // ------------------------------
    // sizes
    localparam int dim_w      = 11;
    localparam int line_len   = 64;
    localparam int col_w      = 6;
    // bit 6 picks one of the two rows held in a bank
    localparam int buf_addr_w = 7;

    // ------------------------------
    // fixed point, 16.16 positions
    localparam int frac_w   = 16;
    localparam int ratio_w  = 16;
    localparam int pos_w    = 27;
    localparam int weight_w = 17;

    // scan strobe to output pixel
    localparam int pipe_lat = 10;

    typedef logic [7:0] pixel_t;

    typedef struct packed {
        logic [dim_w-1:0]   src_width;
        logic [dim_w-1:0]   src_height;
        logic [dim_w-1:0]   dst_width;
        logic [dim_w-1:0]   dst_height;
        logic [ratio_w-1:0] x_ratio;
        logic [ratio_w-1:0] y_ratio;
    } frame_cfg_t;

    // raster stream, in and out
    typedef struct packed {
        logic   vsync;
        logic   href;
        pixel_t pixel;
    } video_t;

    typedef struct packed {
        logic                  en;
        logic                  bank;
        logic [buf_addr_w-1:0] addr;
        pixel_t                pixel;
    } buf_wr_t;

    typedef struct packed {
        logic             active;
        logic             strobe;
        logic [pos_w-1:0] x_pos;
        logic [pos_w-1:0] y_pos;
    } scan_t;

    // x0 is the left column, x1 the one to its right
    typedef struct packed {
        logic [buf_addr_w-1:0] even_x0;
        logic [buf_addr_w-1:0] even_x1;
        logic [buf_addr_w-1:0] odd_x0;
        logic [buf_addr_w-1:0] odd_x1;
    } buf_rd_req_t;

    typedef struct packed {
        pixel_t even_x0;
        pixel_t even_x1;
        pixel_t odd_x0;
        pixel_t odd_x1;
    } buf_rd_data_t;

endpackage

`default_nettype wire

/* verilog/row_writer.sv */
// turns the incoming raster stream into line buffer writes
// one write per valid pixel, plus a strobe when a source row is complete
`timescale 1ns/1ps
`default_nettype none

module row_writer
    import scaler_pkg::*;
(
    input  logic       clk_in2,
    input  logic       rst_n,
    input  frame_cfg_t cfg,
    input  video_t     vin,
    output buf_wr_t    wr,
    output logic       row_done,
    output logic       frame_open
);

    logic [dim_w-1:0] col_cnt;
    logic [dim_w-1:0] row_cnt;
    logic             pix_valid;
    logic             row_last;

    assign pix_valid = vin.vsync && vin.href;
    assign row_last  = pix_valid && (col_cnt == cfg.src_width - 1'b1);

    // position of the current pixel in the source frame
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            col_cnt <= '0;
            row_cnt <= '0;
        end
        else if (!vin.vsync)
        begin
            col_cnt <= '0;
            row_cnt <= '0;
        end
        else if (row_last)
        begin
            col_cnt <= '0;
            row_cnt <= row_cnt + 1'b1;
        end
        else if (pix_valid)
        begin
            col_cnt <= col_cnt + 1'b1;
        end
    end

    // row r goes to bank r[0], slot r[1]
    always_ff @(posedge clk_in2)
    begin
        wr.bank  <= row_cnt[0];
        wr.addr  <= {row_cnt[1], col_cnt[col_w-1:0]};
        wr.pixel <= vin.pixel;
        if (!rst_n)
        begin
            wr.en      <= 1'b0;
            row_done   <= 1'b0;
            frame_open <= 1'b0;
        end
        else
        begin
            wr.en      <= pix_valid;
            row_done   <= row_last;
            frame_open <= vin.vsync;
        end
    end

    // source rows longer than a bank slot would wrap into the other slot
    a_line_len: assert property (@(posedge clk_in2) disable iff (!rst_n)
        pix_valid |-> (col_cnt < line_len))
        else $error("source pixel beyond line_len");

endmodule

`default_nettype wire

/* verilog/line_buffer.sv */
// four-row line buffer split into an even-row bank and an odd-row bank
// each bank has one write port and two registered read ports
// also counts how many rows of the current frame are complete
`timescale 1ns/1ps
`default_nettype none

module line_buffer
    import scaler_pkg::*;
(
    input  logic             clk_in2,
    input  logic             rst_n,
    input  buf_wr_t          wr,
    input  logic             row_done,
    input  logic             frame_open,
    input  buf_rd_req_t      rd_req,
    output buf_rd_data_t     rd_data,
    output logic [dim_w-1:0] rows_ready
);

    // two rows of line_len pixels per bank
    pixel_t even_mem [2**buf_addr_w];
    pixel_t odd_mem  [2**buf_addr_w];

    // ------------------------------
    // write side
    always_ff @(posedge clk_in2)
    begin
        if (wr.en && !wr.bank)
        begin
            even_mem[wr.addr] <= wr.pixel;
        end
    end

    always_ff @(posedge clk_in2)
    begin
        if (wr.en && wr.bank)
        begin
            odd_mem[wr.addr] <= wr.pixel;
        end
    end

    // ------------------------------
    // registered read side
    always_ff @(posedge clk_in2)
    begin
        rd_data.even_x0 <= even_mem[rd_req.even_x0];
        rd_data.even_x1 <= even_mem[rd_req.even_x1];
        rd_data.odd_x0  <= odd_mem[rd_req.odd_x0];
        rd_data.odd_x1  <= odd_mem[rd_req.odd_x1];
    end

    // completed rows in this frame
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            rows_ready <= '0;
        end
        else if (!frame_open)
        begin
            rows_ready <= '0;
        end
        else if (row_done)
        begin
            rows_ready <= rows_ready + 1'b1;
        end
    end

    // a row only completes with its last pixel written inside an open frame
    a_row_write: assert property (@(posedge clk_in2) disable iff (!rst_n)
        row_done |-> (frame_open && wr.en))
        else $error("row_done without the last write of an open frame");

endmodule

`default_nettype wire

/* verilog/scan_controller.sv */
// walks the destination grid in 16.16 fixed point
// a destination row starts only once both source rows it needs are buffered
// drives one strobe per destination pixel, back to back within a row
`timescale 1ns/1ps
`default_nettype none

module scan_controller
    import scaler_pkg::*;
(
    input  logic             clk_in2,
    input  logic             rst_n,
    input  frame_cfg_t       cfg,
    input  logic [dim_w-1:0] rows_ready,
    output scan_t            scan
);

    typedef enum logic [2:0] {
        st_idle,
        st_row_check,
        st_row_scan,
        st_row_advance,
        st_frame_done
    } state_t;

    state_t           state;
    logic [pos_w-1:0] x_acc;
    logic [pos_w-1:0] y_acc;
    logic [dim_w-1:0] x_cnt;
    logic [dim_w-1:0] y_cnt;
    logic             frame_active;
    logic [dim_w-1:0] y_int;
    logic [dim_w:0]   y_next;
    logic             rows_avail;
    logic             row_end;
    logic             last_row;

    assign y_int  = y_acc[pos_w-1:frac_w];
    assign y_next = {1'b0, y_int} + 1'b1;

    // rows y and y+1 present, or y is the last source row and the frame is in
    assign rows_avail = (y_next < {1'b0, rows_ready}) ||
                        ((y_int == cfg.src_height - 1'b1) &&
                         (rows_ready == cfg.src_height));

    assign row_end  = (x_cnt == cfg.dst_width - 1'b1);
    assign last_row = (y_cnt == cfg.dst_height - 1'b1);

    // ------------------------------
    // FSM
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (rows_ready != '0)
                        state <= st_row_check;
                end
                st_row_check:
                begin
                    if (rows_avail)
                        state <= st_row_scan;
                end
                st_row_scan:
                begin
                    if (row_end)
                        state <= st_row_advance;
                end
                st_row_advance:
                begin
                    state <= last_row ? st_frame_done : st_row_check;
                end
                // hold until the input frame has closed
                st_frame_done:
                begin
                    if (rows_ready == '0)
                        state <= st_idle;
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // vertical position, restarts with each frame
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || state == st_idle)
        begin
            y_acc <= '0;
            y_cnt <= '0;
        end
        else if (state == st_row_advance)
        begin
            y_acc <= y_acc + cfg.y_ratio;
            y_cnt <= y_cnt + 1'b1;
        end
    end

    // horizontal position, restarts with each row
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n || state != st_row_scan)
        begin
            x_acc <= '0;
            x_cnt <= '0;
        end
        else
        begin
            x_acc <= x_acc + cfg.x_ratio;
            x_cnt <= x_cnt + 1'b1;
        end
    end

    // first strobe of the frame up to its last strobe
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
            frame_active <= 1'b0;
        else if (state == st_row_check && rows_avail && y_cnt == '0)
            frame_active <= 1'b1;
        else if (state == st_row_scan && row_end && last_row)
            frame_active <= 1'b0;
    end

    assign scan.active = frame_active;
    assign scan.strobe = (state == st_row_scan);
    assign scan.x_pos  = x_acc;
    assign scan.y_pos  = y_acc;

    // rows checked on entry must stay buffered for the whole destination row
    a_rows_present: assert property (@(posedge clk_in2) disable iff (!rst_n)
        scan.strobe |-> rows_avail)
        else $error("strobe uses a source row that is not buffered");

endmodule

`default_nettype wire

/* verilog/bilinear_datapath.sv */
// ten-stage bilinear interpolation pipeline
// weights, buffer reads, bank swap, edge copy, multiply, sum and round
// vsync and href ride along a matching delay line
`timescale 1ns/1ps
`default_nettype none

module bilinear_datapath
    import scaler_pkg::*;
(
    input  logic         clk_in2,
    input  logic         rst_n,
    input  frame_cfg_t   cfg,
    input  scan_t        scan,
    output buf_rd_req_t  rd_req,
    input  buf_rd_data_t rd_data,
    output video_t       vout
);

    typedef struct packed {
        logic [2*weight_w-1:0] w00;
        logic [2*weight_w-1:0] w01;
        logic [2*weight_w-1:0] w10;
        logic [2*weight_w-1:0] w11;
    } weights_t;

    typedef struct packed {
        weights_t w;
        logic     right_edge;
        logic     bottom_edge;
    } tap_ctl_t;

    // ------------------------------
    // sync delay line
    logic [pipe_lat-1:0] vs_dly;
    logic [pipe_lat-1:0] hs_dly;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            vs_dly <= '0;
            hs_dly <= '0;
        end
        else
        begin
            vs_dly <= {vs_dly[pipe_lat-2:0], scan.active};
            hs_dly <= {hs_dly[pipe_lat-2:0], scan.strobe};
        end
    end

    // stage 1, integer and fraction
    logic [dim_w-1:0]    x_int_s1;
    logic [dim_w-1:0]    y_int_s1;
    logic [dim_w-1:0]    y_next_s1;
    logic [weight_w-1:0] x_frac_s1;
    logic [weight_w-1:0] x_inv_s1;
    logic [weight_w-1:0] y_frac_s1;
    logic [weight_w-1:0] y_inv_s1;

    always_ff @(posedge clk_in2)
    begin
        x_int_s1  <= scan.x_pos[pos_w-1:frac_w];
        y_int_s1  <= scan.y_pos[pos_w-1:frac_w];
        x_frac_s1 <= {1'b0, scan.x_pos[frac_w-1:0]};
        y_frac_s1 <= {1'b0, scan.y_pos[frac_w-1:0]};
        x_inv_s1  <= {1'b1, {frac_w{1'b0}}} - {1'b0, scan.x_pos[frac_w-1:0]};
        y_inv_s1  <= {1'b1, {frac_w{1'b0}}} - {1'b0, scan.y_pos[frac_w-1:0]};
    end

    assign y_next_s1 = y_int_s1 + 1'b1;

    // stage 2, weights sum to exactly 2^32
    tap_ctl_t         ctl_s2;
    logic [col_w-1:0] col_l_s2;
    logic [col_w-1:0] col_r_s2;
    logic             even_slot_s2;
    logic             odd_slot_s2;
    logic             upper_odd_s2;

    always_ff @(posedge clk_in2)
    begin
        ctl_s2.w.w00       <= x_inv_s1 * y_inv_s1;
        ctl_s2.w.w01       <= x_frac_s1 * y_inv_s1;
        ctl_s2.w.w10       <= x_inv_s1 * y_frac_s1;
        ctl_s2.w.w11       <= x_frac_s1 * y_frac_s1;
        ctl_s2.right_edge  <= (x_int_s1 == cfg.src_width - 1'b1);
        ctl_s2.bottom_edge <= (y_int_s1 == cfg.src_height - 1'b1);
        col_l_s2           <= x_int_s1[col_w-1:0];
        col_r_s2           <= x_int_s1[col_w-1:0] + 1'b1;
        // even row of the pair is y+1 when y is odd, same slot otherwise
        even_slot_s2       <= y_next_s1[1];
        odd_slot_s2        <= y_int_s1[1];
        upper_odd_s2       <= y_int_s1[0];
    end

    // stage 3, issue reads
    tap_ctl_t ctl_s3;
    logic     upper_odd_s3;

    always_ff @(posedge clk_in2)
    begin
        rd_req.even_x0 <= {even_slot_s2, col_l_s2};
        rd_req.even_x1 <= {even_slot_s2, col_r_s2};
        rd_req.odd_x0  <= {odd_slot_s2, col_l_s2};
        rd_req.odd_x1  <= {odd_slot_s2, col_r_s2};
        ctl_s3         <= ctl_s2;
        upper_odd_s3   <= upper_odd_s2;
    end

    // stage 4, read in flight
    tap_ctl_t ctl_s4;
    logic     upper_odd_s4;

    always_ff @(posedge clk_in2)
    begin
        ctl_s4       <= ctl_s3;
        upper_odd_s4 <= upper_odd_s3;
    end

    // ------------------------------
    // stage 5, order banks as upper and lower row
    tap_ctl_t ctl_s5;
    pixel_t   p00_s5;
    pixel_t   p01_s5;
    pixel_t   p10_s5;
    pixel_t   p11_s5;

    always_ff @(posedge clk_in2)
    begin
        ctl_s5 <= ctl_s4;
        if (upper_odd_s4)
        begin
            p00_s5 <= rd_data.odd_x0;
            p01_s5 <= rd_data.odd_x1;
            p10_s5 <= rd_data.even_x0;
            p11_s5 <= rd_data.even_x1;
        end
        else
        begin
            p00_s5 <= rd_data.even_x0;
            p01_s5 <= rd_data.even_x1;
            p10_s5 <= rd_data.odd_x0;
            p11_s5 <= rd_data.odd_x1;
        end
    end

    // stage 6, replicate at right and bottom edges
    weights_t w_s6;
    pixel_t   p00_s6;
    pixel_t   p01_s6;
    pixel_t   p10_s6;
    pixel_t   p11_s6;

    always_ff @(posedge clk_in2)
    begin
        w_s6   <= ctl_s5.w;
        p00_s6 <= p00_s5;
        p01_s6 <= ctl_s5.right_edge ? p00_s5 : p01_s5;
        case ({ctl_s5.right_edge, ctl_s5.bottom_edge})
            2'b01:
            begin
                p10_s6 <= p00_s5;
                p11_s6 <= p01_s5;
            end
            2'b10:
            begin
                p10_s6 <= p10_s5;
                p11_s6 <= p10_s5;
            end
            2'b11:
            begin
                p10_s6 <= p00_s5;
                p11_s6 <= p00_s5;
            end
            default:
            begin
                p10_s6 <= p10_s5;
                p11_s6 <= p11_s5;
            end
        endcase
    end

    // stages 7 to 9, multiply and add tree
    logic [2*weight_w+7:0] prod00_s7;
    logic [2*weight_w+7:0] prod01_s7;
    logic [2*weight_w+7:0] prod10_s7;
    logic [2*weight_w+7:0] prod11_s7;
    logic [2*weight_w+8:0] sum_top_s8;
    logic [2*weight_w+8:0] sum_bot_s8;
    logic [2*weight_w+9:0] sum_s9;
    pixel_t                pixel_s10;

    always_ff @(posedge clk_in2)
    begin
        prod00_s7  <= w_s6.w00 * p00_s6;
        prod01_s7  <= w_s6.w01 * p01_s6;
        prod10_s7  <= w_s6.w10 * p10_s6;
        prod11_s7  <= w_s6.w11 * p11_s6;
        sum_top_s8 <= prod00_s7 + prod01_s7;
        sum_bot_s8 <= prod10_s7 + prod11_s7;
        sum_s9     <= sum_top_s8 + sum_bot_s8;
        // round half up, result stays within 255
        pixel_s10  <= sum_s9[2*frac_w+7:2*frac_w] + sum_s9[2*frac_w-1];
    end

    assign vout.vsync = vs_dly[pipe_lat-1];
    assign vout.href  = hs_dly[pipe_lat-1];
    assign vout.pixel = pixel_s10;

endmodule

`default_nettype wire

/* verilog/bilinear_scaler.sv */
// bilinear grayscale scaler top level
// row writer feeds the line buffer, the scan controller drives the datapath
`timescale 1ns/1ps
`default_nettype none

module bilinear_scaler
    import scaler_pkg::*;
(
    input  logic       clk_in2,
    input  logic       rst_n,
    input  frame_cfg_t cfg,
    input  video_t     vin,
    output video_t     vout
);

    buf_wr_t          wr;
    logic             row_done;
    logic             frame_open;
    buf_rd_req_t      rd_req;
    buf_rd_data_t     rd_data;
    logic [dim_w-1:0] rows_ready;
    scan_t            scan;

    // ------------------------------
    // source side
    row_writer u_row_writer (
        .clk_in2    (clk_in2),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .vin        (vin),
        .wr         (wr),
        .row_done   (row_done),
        .frame_open (frame_open)
    );

    line_buffer u_line_buffer (
        .clk_in2    (clk_in2),
        .rst_n      (rst_n),
        .wr         (wr),
        .row_done   (row_done),
        .frame_open (frame_open),
        .rd_req     (rd_req),
        .rd_data    (rd_data),
        .rows_ready (rows_ready)
    );

    // ------------------------------
    // destination side
    scan_controller u_scan_controller (
        .clk_in2    (clk_in2),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .rows_ready (rows_ready),
        .scan       (scan)
    );

    bilinear_datapath u_bilinear_datapath (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .scan    (scan),
        .rd_req  (rd_req),
        .rd_data (rd_data),
        .vout    (vout)
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
// clock and reset source for the scaler testbench
// 8 ns clock, reset held low for the first 10 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_in2,
    output logic rst_n
);

    localparam int half_period  = 4;
    localparam int reset_cycles = 10;

    initial
    begin
        clk_in2 = 1'b0;
        forever
            #half_period clk_in2 = ~clk_in2;
    end

    // released just after an edge, like the rest of the stimulus
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_in2);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_ref_model.svh */
// frame table, source image patterns and the bilinear reference model
// included in the body of the testbench top, after its scaler_pkg import
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int n_frames   = 5;
localparam int pat_ramp   = 0;
localparam int pat_const  = 1;
localparam int pat_random = 2;

typedef struct packed {
    frame_cfg_t cfg;
    logic [1:0] pattern;
    pixel_t     fill;
} frame_entry_t;

frame_entry_t frame_table [n_frames];
// source image, row major with line_len pixels per row
pixel_t       src_img [line_len*line_len];
int           seed = 57292;

function automatic frame_entry_t make_entry(
    input int sw,
    input int sh,
    input int dw,
    input int dh,
    input int xr,
    input int yr,
    input int pat,
    input int fill
);
    frame_entry_t e;
    e.cfg.src_width  = dim_w'(sw);
    e.cfg.src_height = dim_w'(sh);
    e.cfg.dst_width  = dim_w'(dw);
    e.cfg.dst_height = dim_w'(dh);
    e.cfg.x_ratio    = ratio_w'(xr);
    e.cfg.y_ratio    = ratio_w'(yr);
    e.pattern        = 2'(pat);
    e.fill           = pixel_t'(fill);
    return e;
endfunction

task automatic load_table();
    // ratio field tops out just below 1.0, so 0xffff gives a 1:1 copy
    frame_table[0] = make_entry(8, 6, 8, 6, 'hffff, 'hffff, pat_random, 0);
    frame_table[1] = make_entry(8, 6, 16, 12, 'h8000, 'h8000, pat_ramp, 0);
    // last column and row land between a pixel and the edge
    frame_table[2] = make_entry(10, 7, 20, 14, 'h8000, 'h8000, pat_random, 0);
    // x and y scaled differently
    frame_table[3] = make_entry(12, 5, 16, 10, 'hc000, 'h8000, pat_random, 0);
    frame_table[4] = make_entry(7, 5, 9, 6, 'hc000, 'hc000, pat_const, 'ha5);
endtask

task automatic fill_image(input frame_entry_t e);
    int r;
    int c;
    for (r = 0; r < int'(e.cfg.src_height); r++)
    begin
        for (c = 0; c < int'(e.cfg.src_width); c++)
        begin
            case (int'(e.pattern))
                pat_ramp:  src_img[r*line_len + c] = pixel_t'(r * 23 + c * 9);
                pat_const: src_img[r*line_len + c] = e.fill;
                default:   src_img[r*line_len + c] = pixel_t'($random(seed));
            endcase
        end
    end
endtask

function automatic pixel_t pixel_at(input int row, input int col);
    if (row < 0 || col < 0 || row >= line_len || col >= line_len)
        return '0;
    return src_img[row*line_len + col];
endfunction

// ------------------------------
// bilinear reference, 16.16 positions and 32-bit fraction weights
function automatic pixel_t ref_pixel(input frame_entry_t e, input int row, input int col);
    logic [63:0] one;
    logic [63:0] x_pos;
    logic [63:0] y_pos;
    logic [63:0] fx;
    logic [63:0] fy;
    logic [63:0] sum;
    int          x0;
    int          x1;
    int          y0;
    int          y1;
    one   = 64'h1_0000;
    x_pos = 64'(col) * 64'(e.cfg.x_ratio);
    y_pos = 64'(row) * 64'(e.cfg.y_ratio);
    x0    = int'(x_pos >> frac_w);
    y0    = int'(y_pos >> frac_w);
    fx    = x_pos & 64'hffff;
    fy    = y_pos & 64'hffff;
    // right and bottom edges reuse the left and top neighbours
    x1    = (x0 == int'(e.cfg.src_width) - 1) ? x0 : x0 + 1;
    y1    = (y0 == int'(e.cfg.src_height) - 1) ? y0 : y0 + 1;
    sum   = (one - fx) * (one - fy) * 64'(pixel_at(y0, x0)) +
            fx * (one - fy) * 64'(pixel_at(y0, x1)) +
            (one - fx) * fy * 64'(pixel_at(y1, x0)) +
            fx * fy * 64'(pixel_at(y1, x1));
    // round half up at bit 31
    return pixel_t'((sum >> 32) + ((sum >> 31) & 64'd1));
endfunction

`endif

/* sim/tb_bilinear_scaler.sv */
// testbench for the bilinear scaler
// sends every frame of the table and checks the output stream pixel by pixel
`timescale 1ns/1ps
`default_nettype none

module tb_bilinear_scaler
    import scaler_pkg::*;
();

    localparam int frame_timeout = 20000;
    localparam int reset_timeout = 100;

    logic       clk_in2;
    logic       rst_n;
    frame_cfg_t cfg;
    video_t     vin;
    video_t     vout;

    int   cur_frame   = 0;
    int   frames_done = 0;
    logic frame_armed = 1'b0;

    `include "tb_ref_model.svh"

    tb_clock_gen u_clock_gen (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n)
    );

    bilinear_scaler DUT (
        .clk_in2 (clk_in2),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .vin     (vin),
        .vout    (vout)
    );

    // ------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timed out while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation timeout");
    endtask

    task automatic next_cycle();
        @(posedge clk_in2);
        #1;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < reset_timeout)
        begin
            @(negedge clk_in2);
            cycles++;
        end
        if (rst_n !== 1'b1)
            timeout_abort("reset release");
        next_cycle();
    endtask

    // one source frame with rows spaced by the input pacing gap
    task automatic send_frame(input frame_entry_t e);
        int r;
        int c;
        int gap;
        int cycles;
        gap         = 3 * (int'(e.cfg.dst_width) + 4);
        cfg         = e.cfg;
        frame_armed = 1'b1;
        vin.vsync   = 1'b1;
        vin.href    = 1'b0;
        vin.pixel   = '0;
        repeat (4) next_cycle();
        for (r = 0; r < int'(e.cfg.src_height); r++)
        begin
            for (c = 0; c < int'(e.cfg.src_width); c++)
            begin
                vin.href  = 1'b1;
                vin.pixel = src_img[r*line_len + c];
                next_cycle();
            end
            vin.href  = 1'b0;
            vin.pixel = '0;
            repeat (gap) next_cycle();
        end
        // input frame stays open until the output frame has closed
        cycles = 0;
        while (frames_done <= cur_frame && cycles < frame_timeout)
        begin
            next_cycle();
            cycles++;
        end
        if (frames_done <= cur_frame)
            timeout_abort("the end of an output frame");
        vin.vsync = 1'b0;
        repeat (8) next_cycle();
    endtask

    // ------------------------------
    // output collector sampling on the falling edge
    initial
    begin
        logic         prev_vsync;
        logic         prev_href;
        int           out_row;
        int           out_col;
        frame_entry_t e;
        prev_vsync = 1'b0;
        prev_href  = 1'b0;
        out_row    = 0;
        out_col    = 0;
        @(posedge clk_in2);
        forever
        begin
            @(negedge clk_in2);
            e = frame_table[cur_frame];
            if (!frame_armed)
                check_value("output active outside a frame", {vout.vsync, vout.href}, 0);
            if (vout.vsync && !prev_vsync)
            begin
                out_row = 0;
                out_col = 0;
            end
            if (vout.href)
            begin
                check_value("href outside vsync", vout.vsync, 1);
                check_value($sformatf("frame %0d pixel row %0d col %0d", cur_frame,
                                      out_row, out_col),
                            vout.pixel, ref_pixel(e, out_row, out_col));
                // 1:1 entry must reproduce the source image
                if (e.cfg.x_ratio == 16'hffff && e.cfg.y_ratio == 16'hffff)
                    check_value("identity copy", vout.pixel, pixel_at(out_row, out_col));
                out_col++;
            end
            if (!vout.href && prev_href)
            begin
                check_value("pixels in output row", out_col, e.cfg.dst_width);
                out_row++;
                out_col = 0;
            end
            if (!vout.vsync && prev_vsync)
            begin
                check_value("rows in output frame", out_row, e.cfg.dst_height);
                frame_armed = 1'b0;
                frames_done++;
            end
            prev_vsync = vout.vsync;
            prev_href  = vout.href;
        end
    end

    // ------------------------------
    // frame loop
    initial
    begin
        int i;
        cfg = '0;
        vin = '0;
        load_table();
        wait_reset_release();
        for (i = 0; i < n_frames; i++)
        begin
            cur_frame = i;
            fill_image(frame_table[i]);
            send_frame(frame_table[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+sim
verilog/scaler_pkg.sv
verilog/row_writer.sv
verilog/line_buffer.sv
verilog/scan_controller.sv
verilog/bilinear_datapath.sv
verilog/bilinear_scaler.sv
sim/tb_clock_gen.sv
sim/tb_bilinear_scaler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the bilinear scaler testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bilinear_scaler \
    --Mdir obj_dir -o tb_sim \
    -f all.f

./obj_dir/tb_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
